// File: include/dcmp_params.svh
// Sizing for the packed configuration stream decompressor
// DCMP_FIFO_DEPTH must be a power of two and at most 4
// The source starts with DCMP_FIFO_DEPTH credits and the DUT with DCMP_OUT_CREDITS

`ifndef DCMP_PARAMS_SVH
`define DCMP_PARAMS_SVH

// Width of flash words and of output words
`define DCMP_WORD_W 16

// Packet length field, a packet emits N+1 words
`define DCMP_LEN_W 12

// Input word FIFO depth, equal to the source's initial credits
`define DCMP_FIFO_DEPTH 4

// Downstream credits held by the output stage after reset
`define DCMP_OUT_CREDITS 4

`endif

// File: verilog/dcmp_pkg.sv
// Shared types of the stream decompressor
// Header type codes not listed here decode as zero fill

`include "dcmp_params.svh"

package dcmp_pkg;

	// ************************************************************************
	// Data types
	// ************************************************************************

	// One flash or output word
	typedef logic [`DCMP_WORD_W-1:0] dcmp_word_t;

	// Packet length N, the packet carries N+1 words
	typedef logic [`DCMP_LEN_W-1:0] dcmp_len_t;

	// Header type code, bits 6..4 of the header byte
	typedef enum logic [2:0] {
		OP_ZERO   = 3'b000,
		OP_VALUE  = 3'b010,
		OP_NIBBLE = 3'b100,
		OP_RAW    = 3'b101,
		OP_ONES   = 3'b111
	} dcmp_op_e;

	// ************************************************************************
	// Decoder FSM
	// ************************************************************************

	typedef enum logic [1:0] {
		ST_HEADER,
		ST_FILL,
		ST_COPY
	} dcmp_state_e;

endpackage

// File: verilog/flash_word_fifo.sv
// Input word FIFO; the source must hold a credit for every word it writes,
// the FIFO has no overflow guard of its own
// Pops only ever touch words counted in fill_count

`include "dcmp_params.svh"

module flash_word_fifo (
	input  logic                 clk,
	input  logic                 nreset,
	input  logic                 in_valid,
	input  dcmp_pkg::dcmp_word_t in_data,
	input  logic                 pop_one,
	input  logic                 pop_two,
	output logic [1:0]           in_credit,
	output dcmp_pkg::dcmp_word_t head0,
	output dcmp_pkg::dcmp_word_t head1,
	output logic [2:0]           fill_count
);

	localparam int PTR_W = $clog2(`DCMP_FIFO_DEPTH);

	dcmp_pkg::dcmp_word_t mem [`DCMP_FIFO_DEPTH];

	logic [PTR_W-1:0] wr_ptr;
	logic [PTR_W-1:0] rd_ptr;
	logic [PTR_W-1:0] rd_ptr_next;
	logic [2:0]       count;
	logic [1:0]       pop_cnt;

	// ************************************************************************
	// Pop request
	// ************************************************************************

	// Number of words the decoder takes this cycle
	assign pop_cnt = pop_two ? 2'd2 : (pop_one ? 2'd1 : 2'd0);

	// ************************************************************************
	// Storage
	// ************************************************************************

	always_ff @(posedge clk) begin
		if (in_valid) begin
			mem[wr_ptr] <= in_data;
		end
	end

	// Pointers wrap naturally since the depth is a power of two
	always_ff @(posedge clk) begin
		if (!nreset) begin
			wr_ptr    <= '0;
			rd_ptr    <= '0;
			count     <= '0;
			in_credit <= 2'd0;
		end else begin
			if (in_valid) begin
				wr_ptr <= wr_ptr + 1'b1;
			end
			rd_ptr <= rd_ptr + PTR_W'(pop_cnt);
			count  <= count + {2'b00, in_valid} - {1'b0, pop_cnt};
			// Freed slots go back to the source one cycle after the pop
			in_credit <= pop_cnt;
		end
	end

	// ************************************************************************
	// Head words for the decoder
	// ************************************************************************

	assign rd_ptr_next = rd_ptr + 1'b1;

	// head1 is only meaningful when two or more words are stored
	assign head0      = mem[rd_ptr];
	assign head1      = mem[rd_ptr_next];
	assign fill_count = count;

endmodule

// File: verilog/packet_decoder.sv
// Packet header decoder and fill/copy word generator
// Emits at most one word per cycle, and only while can_accept is high
// Unsupported type codes, nibble included, expand as zero fill

module packet_decoder (
	input  logic                 clk,
	input  logic                 nreset,
	input  dcmp_pkg::dcmp_word_t head0,
	input  dcmp_pkg::dcmp_word_t head1,
	input  logic [2:0]           fill_count,
	input  logic                 can_accept,
	output logic                 pop_one,
	output logic                 pop_two,
	output logic                 word_valid,
	output dcmp_pkg::dcmp_word_t word
);

	dcmp_pkg::dcmp_state_e state;
	dcmp_pkg::dcmp_len_t   remain;
	dcmp_pkg::dcmp_word_t  fill_word;

	logic                 hdr_long;
	dcmp_pkg::dcmp_op_e   hdr_op;
	dcmp_pkg::dcmp_len_t  hdr_len;
	logic [7:0]           hdr_byte;
	logic                 hdr_two_words;
	logic                 hdr_ready;
	dcmp_pkg::dcmp_word_t hdr_fill;
	logic                 last_word;

	// ************************************************************************
	// Header field decode
	// ************************************************************************

	// Header byte sits in the low half of head0
	assign hdr_long = head0[7];
	assign hdr_op   = dcmp_pkg::dcmp_op_e'(head0[6:4]);

	// Long form puts byte 1 above the four low length bits
	assign hdr_len = hdr_long ? {head0[15:8], head0[3:0]} : {8'h00, head0[3:0]};

	// Only a long value header spills into a second word
	assign hdr_two_words = hdr_long && (hdr_op == dcmp_pkg::OP_VALUE);

	// Fill byte is byte 1 for short headers, byte 2 for long ones
	assign hdr_byte = hdr_long ? head1[7:0] : head0[15:8];

	// Whole header must be stored before it is taken
	always_comb begin
		hdr_ready = 1'b0;
		if (state == dcmp_pkg::ST_HEADER) begin
			if (hdr_two_words) begin
				hdr_ready = (fill_count >= 3'd2);
			end else begin
				hdr_ready = (fill_count != 3'd0);
			end
		end
	end

	// Word repeated for the whole packet
	always_comb begin
		case (hdr_op)
			dcmp_pkg::OP_ONES:  hdr_fill = '1;
			dcmp_pkg::OP_VALUE: hdr_fill = {hdr_byte, hdr_byte};
			default:            hdr_fill = '0;
		endcase
	end

	// ************************************************************************
	// Word generation and FIFO pops
	// ************************************************************************

	assign last_word = (remain == '0);

	always_comb begin
		pop_one    = 1'b0;
		pop_two    = 1'b0;
		word_valid = 1'b0;
		word       = fill_word;
		case (state)
			dcmp_pkg::ST_HEADER: begin
				pop_two = hdr_ready && hdr_two_words;
				pop_one = hdr_ready && !hdr_two_words;
			end
			dcmp_pkg::ST_FILL: begin
				word_valid = can_accept;
			end
			dcmp_pkg::ST_COPY: begin
				// Raw data passes straight from the FIFO head
				word_valid = can_accept && (fill_count != 3'd0);
				pop_one    = word_valid;
				word       = head0;
			end
			default: begin
				word_valid = 1'b0;
			end
		endcase
	end

	// ************************************************************************
	// FSM and length counter
	// ************************************************************************

	always_ff @(posedge clk) begin
		if (!nreset) begin
			state  <= dcmp_pkg::ST_HEADER;
			remain <= '0;
		end else begin
			case (state)
				dcmp_pkg::ST_HEADER: begin
					if (hdr_ready) begin
						remain <= hdr_len;
						if (hdr_op == dcmp_pkg::OP_RAW) begin
							state <= dcmp_pkg::ST_COPY;
						end else begin
							state <= dcmp_pkg::ST_FILL;
						end
					end
				end
				dcmp_pkg::ST_FILL,
				dcmp_pkg::ST_COPY: begin
					// Counter runs N down to zero, the zero word is the last
					if (word_valid) begin
						if (last_word) begin
							state <= dcmp_pkg::ST_HEADER;
						end else begin
							remain <= remain - 1'b1;
						end
					end
				end
				default: begin
					state <= dcmp_pkg::ST_HEADER;
				end
			endcase
		end
	end

	// Fill word is captured with the header
	always_ff @(posedge clk) begin
		if (hdr_ready) begin
			fill_word <= hdr_fill;
		end
	end

endmodule

// File: verilog/credit_output.sv
// Registered output stage with downstream credit tracking
// The sink returns one out_credit pulse per word it consumes

`include "dcmp_params.svh"

module credit_output (
	input  logic                 clk,
	input  logic                 nreset,
	input  logic                 word_valid,
	input  dcmp_pkg::dcmp_word_t word,
	input  logic                 out_credit,
	output logic                 can_accept,
	output logic                 out_valid,
	output dcmp_pkg::dcmp_word_t out_data
);

	localparam int CRD_W = $clog2(`DCMP_OUT_CREDITS + 1);

	logic [CRD_W-1:0] credits;
	logic             accept;

	// Decoder may send while any credit is left
	assign can_accept = (credits != '0);
	assign accept     = word_valid && can_accept;

	// ************************************************************************
	// Credit counter and valid
	// ************************************************************************

	always_ff @(posedge clk) begin
		if (!nreset) begin
			credits   <= CRD_W'(`DCMP_OUT_CREDITS);
			out_valid <= 1'b0;
		end else begin
			out_valid <= accept;
			case ({accept, out_credit})
				2'b10:   credits <= credits - 1'b1;
				2'b01:   credits <= credits + 1'b1;
				// Send and return together cancel out
				default: credits <= credits;
			endcase
		end
	end

	// Output data register
	always_ff @(posedge clk) begin
		if (accept) begin
			out_data <= word;
		end
	end

endmodule

// File: verilog/packet_decompressor.sv
// Stream decompressor top, runs continuously once nreset is released
// Credit-based handshakes on both the flash side and the output side

module packet_decompressor (
	input  logic                 clk,
	input  logic                 nreset,
	input  logic                 in_valid,
	input  dcmp_pkg::dcmp_word_t in_data,
	input  logic                 out_credit,
	output logic [1:0]           in_credit,
	output logic                 out_valid,
	output dcmp_pkg::dcmp_word_t out_data
);

	dcmp_pkg::dcmp_word_t head0;
	dcmp_pkg::dcmp_word_t head1;
	logic [2:0]           fill_count;
	logic                 pop_one;
	logic                 pop_two;
	logic                 word_valid;
	dcmp_pkg::dcmp_word_t word;
	logic                 can_accept;

	// Flash words in, two head words out
	flash_word_fifo fifo0 (
		.clk        (clk),
		.nreset     (nreset),
		.in_valid   (in_valid),
		.in_data    (in_data),
		.pop_one    (pop_one),
		.pop_two    (pop_two),
		.in_credit  (in_credit),
		.head0      (head0),
		.head1      (head1),
		.fill_count (fill_count)
	);

	packet_decoder decoder0 (
		.clk        (clk),
		.nreset     (nreset),
		.head0      (head0),
		.head1      (head1),
		.fill_count (fill_count),
		.can_accept (can_accept),
		.pop_one    (pop_one),
		.pop_two    (pop_two),
		.word_valid (word_valid),
		.word       (word)
	);

	credit_output output0 (
		.clk        (clk),
		.nreset     (nreset),
		.word_valid (word_valid),
		.word       (word),
		.out_credit (out_credit),
		.can_accept (can_accept),
		.out_valid  (out_valid),
		.out_data   (out_data)
	);

endmodule

// File: verification/tb_packet_decompressor.sv
// Testbench for the stream decompressor; builds a packet stream, expands it in a
// reference model and checks the DUT output under random credit return on both sides
// Stops at the first mismatch or protocol error

`include "dcmp_params.svh"

module tb_packet_decompressor;

	logic                 clk;
	logic                 nreset;
	logic                 in_valid;
	dcmp_pkg::dcmp_word_t in_data;
	logic                 out_credit;
	logic [1:0]           in_credit;
	logic                 out_valid;
	dcmp_pkg::dcmp_word_t out_data;

	integer seed = 32'hf5a8_9992;
	dcmp_pkg::dcmp_word_t in_words [$];
	dcmp_pkg::dcmp_word_t exp_words [$];
	int credit_due [$];
	int cycle = 0;
	int limit = 0;
	int exp_total = 0;
	int received = 0;
	int src_idx = 0;
	int src_credits = 0;
	int words_sent = 0;
	int in_credit_total = 0;
	int outstanding = 0;
	int k;

	packet_decompressor dut0 (
		.clk        (clk),
		.nreset     (nreset),
		.in_valid   (in_valid),
		.in_data    (in_data),
		.out_credit (out_credit),
		.in_credit  (in_credit),
		.out_valid  (out_valid),
		.out_data   (out_data)
	);

	always #5 clk = ~clk;

	// ************************************************************************
	// Failure reporting and compare tasks
	// ************************************************************************

	task automatic fail_run(input string what);
		$display("%s", what);
		$display("CHECKS FAILED");
		$fatal(1);
	endtask

	task automatic check_word(input dcmp_pkg::dcmp_word_t got,
			input dcmp_pkg::dcmp_word_t expected);
		if (got !== expected) begin
			fail_run($sformatf("** Error: out_data got %h expected %h", got, expected));
		end
	endtask

	task automatic check_count(input int got, input int expected);
		if (got != expected) begin
			fail_run($sformatf("** Error: in_credit total got %h expected %h", got, expected));
		end
	endtask

	// ************************************************************************
	// Stream builder and reference expander
	// ************************************************************************

	// Header byte is {long, type, len[3:0]}, byte 1 is the fill byte or length high bits
	task automatic add_packet(input logic [2:0] op, input logic is_long, input logic [11:0] n,
			input logic [7:0] fill);
		logic [7:0] pad;
		int i;
		pad = $random(seed);
		if (is_long) begin
			in_words.push_back({n[11:4], 1'b1, op, n[3:0]});
			if (op == 3'b010) begin
				in_words.push_back({pad, fill});
			end
		end else begin
			in_words.push_back({(op == 3'b010) ? fill : pad, 1'b0, op, n[3:0]});
		end
		if (op == 3'b101) begin
			for (i = 0; i <= n; i++) begin
				in_words.push_back($random(seed));
			end
		end
	endtask

	function automatic int expand_stream();
		int idx;
		int j;
		logic [15:0] h;
		logic [11:0] n;
		logic [7:0] b;
		dcmp_pkg::dcmp_word_t fill;
		idx = 0;
		while (idx < in_words.size()) begin
			h = in_words[idx];
			n = h[7] ? {h[15:8], h[3:0]} : {8'h00, h[3:0]};
			b = h[15:8];
			idx = idx + 1;
			// Long value header carries its fill byte in the next word
			if (h[7] && h[6:4] == 3'b010) begin
				b = in_words[idx][7:0];
				idx = idx + 1;
			end
			case (h[6:4])
				3'b111:  fill = 16'hffff;
				3'b010:  fill = {b, b};
				default: fill = 16'h0000;
			endcase
			for (j = 0; j <= n; j++) begin
				if (h[6:4] == 3'b101) begin
					exp_words.push_back(in_words[idx]);
					idx = idx + 1;
				end else begin
					exp_words.push_back(fill);
				end
			end
		end
		return exp_words.size();
	endfunction

	// ************************************************************************
	// Credited source, sink and monitor
	// ************************************************************************

	always @(posedge clk) begin
		cycle <= cycle + 1;
		if (cycle >= limit) begin
			fail_run($sformatf("timeout after %0d cycles, %0d of %0d words received",
				cycle, received, exp_total));
		end
	end

	always @(posedge clk) begin
		if (!nreset) begin
			src_credits = `DCMP_FIFO_DEPTH;
			src_idx = 0;
			in_valid <= 1'b0;
		end else begin
			src_credits = src_credits + in_credit;
			if (src_credits > 0 && src_idx < in_words.size() &&
					($unsigned($random(seed)) % 4) != 0) begin
				in_valid <= 1'b1;
				in_data <= in_words[src_idx];
				src_idx = src_idx + 1;
				src_credits = src_credits - 1;
			end else begin
				in_valid <= 1'b0;
			end
		end
	end

	// Each word gets its credit back after 0 to 7 cycles
	always @(posedge clk) begin
		if (!nreset) begin
			out_credit <= 1'b0;
		end else begin
			if (out_valid) begin
				credit_due.push_back(cycle + ($unsigned($random(seed)) % 8));
			end
			if (credit_due.size() != 0 && credit_due[0] <= cycle) begin
				credit_due.delete(0);
				out_credit <= 1'b1;
			end else begin
				out_credit <= 1'b0;
			end
		end
	end

	always @(posedge clk) begin
		if (nreset) begin
			if (in_valid && words_sent + 1 > in_credit_total + `DCMP_FIFO_DEPTH) begin
				fail_run("source sent a word without holding a credit");
			end
			if (in_valid) begin
				words_sent = words_sent + 1;
			end
			in_credit_total = in_credit_total + in_credit;
			if (out_credit) begin
				outstanding = outstanding - 1;
			end
			if (out_valid) begin
				outstanding = outstanding + 1;
				if (outstanding > `DCMP_OUT_CREDITS) begin
					fail_run("output overran its credits");
				end
				if (exp_words.size() == 0) begin
					fail_run("out_valid seen with no expected word left");
				end
				check_word(out_data, exp_words.pop_front());
				received = received + 1;
			end
		end
	end

	// ************************************************************************
	// Test sequence
	// ************************************************************************

	initial begin
		clk = 1'b0;
		nreset = 1'b0;
		in_valid = 1'b0;
		in_data = '0;
		out_credit = 1'b0;
		add_packet(3'b000, 1'b0, 12'd3, 8'h00);
		add_packet(3'b000, 1'b1, 12'd20, 8'h00);
		add_packet(3'b111, 1'b0, 12'd0, 8'h00);
		add_packet(3'b111, 1'b1, 12'd33, 8'h00);
		add_packet(3'b010, 1'b0, 12'd5, 8'ha5);
		add_packet(3'b010, 1'b1, 12'd18, 8'h3c);
		add_packet(3'b101, 1'b0, 12'd7, 8'h00);
		add_packet(3'b101, 1'b1, 12'd40, 8'h00);
		add_packet(3'b010, 1'b0, 12'd2, 8'h5a);
		// Nibble code expands as zero fill
		add_packet(3'b100, 1'b0, 12'd2, 8'h00);
		add_packet(3'b101, 1'b1, 12'd16, 8'h00);
		add_packet(3'b111, 1'b0, 12'd15, 8'h00);
		for (k = 0; k < 8; k++) begin
			add_packet(($unsigned($random(seed)) % 2) ? 3'b101 : 3'b010, k[0],
				k[0] ? 12'($unsigned($random(seed)) % 41) : 12'($unsigned($random(seed)) % 16),
				$random(seed));
		end
		exp_total = expand_stream();
		limit = 20 * (in_words.size() + exp_total) + 200;
		repeat (3) @(posedge clk);
		nreset <= 1'b1;
		wait (received == exp_total);
		// Quiet window, any further out_valid fails in the monitor
		repeat (20) @(posedge clk);
		@(negedge clk);
		check_count(in_credit_total, in_words.size());
		$display("ALL CHECKS PASSED");
		$finish;
	end

endmodule

// File: packet_decompressor.f
+incdir+include
verilog/dcmp_pkg.sv
verilog/flash_word_fifo.sv
verilog/packet_decoder.sv
verilog/credit_output.sv
verilog/packet_decompressor.sv
verification/tb_packet_decompressor.sv
